//--- source/dbus_pkg.sv
`default_nettype none

package dbus_pkg;

    // Address bits 31:30 select the target. Codes 2 and 3 both go to the external bus.
    localparam logic [1:0] REGION_RAM = 2'd0;
    localparam logic [1:0] REGION_REGS = 2'd1;

    // On-chip data RAM of 8 KB.
    localparam int RAM_WORDS = 2048;
    localparam int RAM_ADDR_W = $clog2(RAM_WORDS);

    // Register word offsets, from byte address bits 3:2.
    localparam logic [1:0] REG_PROTECT = 2'd0;
    localparam logic [1:0] REG_SCRATCH = 2'd1;
    localparam logic [1:0] REG_BLOCKED = 2'd2;
    localparam logic [1:0] REG_ID = 2'd3;

    localparam logic [31:0] DBUS_ID = 32'h5e7a_0001;

endpackage

`default_nettype wire

//--- source/wb_if.sv
`timescale 1ns/10ps
`default_nettype none

interface wb_if;

    logic [31:0] adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic [3:0] sel;
    logic we;
    logic cyc;
    logic stb;
    logic ack;

    modport master (
        output adr,
        output dat_w,
        output sel,
        output we,
        output cyc,
        output stb,
        input dat_r,
        input ack
    );

    modport slave (
        input adr,
        input dat_w,
        input sel,
        input we,
        input cyc,
        input stb,
        output dat_r,
        output ack
    );

endinterface

`default_nettype wire

//--- source/sp_ram.sv
`timescale 1ns/10ps
`default_nettype none

module sp_ram (
    input wire ck,
    input wire i_reset,
    wb_if.slave bus,
    input wire logic [dbus_pkg::RAM_ADDR_W:0] i_protect_limit,
    output logic o_blocked_write
);

    logic [31:0] mem [0:dbus_pkg::RAM_WORDS-1];
    logic [31:0] rdata_q;
    logic ack_q;
    logic [dbus_pkg::RAM_ADDR_W-1:0] word_adr;
    logic req;
    logic below_limit;
    logic write_ok;

    assign word_adr = bus.adr[dbus_pkg::RAM_ADDR_W-1:0];

    // A request is accepted once and then acknowledged in the following cycle.
    assign req = bus.cyc & bus.stb & ~ack_q;

    assign below_limit = {1'b0, word_adr} < i_protect_limit;
    assign write_ok = req & bus.we & ~below_limit;

    // Seen by the register block at the edge where the write is dropped.
    assign o_blocked_write = req & bus.we & below_limit;

    always_ff @(posedge ck) begin
        if (i_reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    always_ff @(posedge ck) begin
        if (req) begin
            for (int i = 0; i < 4; i++) begin
                if (write_ok && bus.sel[i]) begin
                    mem[word_adr][8*i +: 8] <= bus.dat_w[8*i +: 8];
                end
            end
            rdata_q <= mem[word_adr]; // Old contents on a write cycle.
        end
    end

    assign bus.ack = ack_q;
    assign bus.dat_r = rdata_q;

    // The master must see a gap before its next transfer is accepted.
    a_ack_single: assert property (
        @(posedge ck) disable iff (i_reset)
        bus.ack |=> !bus.ack
    );

endmodule

`default_nettype wire

//--- source/ctrl_regs.sv
`timescale 1ns/10ps
`default_nettype none

module ctrl_regs (
    input wire ck,
    input wire i_reset,
    wb_if.slave bus,
    input wire logic i_blocked_write,
    output logic [dbus_pkg::RAM_ADDR_W:0] o_protect_limit
);

    logic [dbus_pkg::RAM_ADDR_W:0] protect_q;
    logic [31:0] scratch_q;
    logic [31:0] blocked_q;
    logic [31:0] rdata_q;
    logic [31:0] reg_rdata;
    logic [31:0] protect_merged;
    logic [1:0] reg_idx;
    logic ack_q;
    logic req;
    logic wr;

    function automatic logic [31:0] lane_merge(
        input logic [31:0] old_w,
        input logic [31:0] new_w,
        input logic [3:0] sel
    );
        logic [31:0] res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign reg_idx = bus.adr[1:0];
    assign req = bus.cyc & bus.stb & ~ack_q;
    assign wr = req & bus.we;

    // Only the low bits are kept, so the upper lanes fall away.
    assign protect_merged = lane_merge(32'(protect_q), bus.dat_w, bus.sel);

    always_ff @(posedge ck) begin
        if (i_reset) begin
            ack_q <= 1'b0;
            protect_q <= '0;
            scratch_q <= '0;
            blocked_q <= '0;
        end else begin
            ack_q <= req;
            if (wr && reg_idx == dbus_pkg::REG_PROTECT) begin
                protect_q <= protect_merged[dbus_pkg::RAM_ADDR_W:0];
            end
            if (wr && reg_idx == dbus_pkg::REG_SCRATCH) begin
                scratch_q <= lane_merge(scratch_q, bus.dat_w, bus.sel);
            end
            if (wr && reg_idx == dbus_pkg::REG_BLOCKED) begin
                blocked_q <= '0; // A clear beats a pulse in the same cycle.
            end else if (i_blocked_write) begin
                blocked_q <= blocked_q + 32'd1;
            end
        end
    end

    always_comb begin
        case (reg_idx)
            dbus_pkg::REG_PROTECT: reg_rdata = 32'(protect_q);
            dbus_pkg::REG_SCRATCH: reg_rdata = scratch_q;
            dbus_pkg::REG_BLOCKED: reg_rdata = blocked_q;
            dbus_pkg::REG_ID:      reg_rdata = dbus_pkg::DBUS_ID;
            default:               reg_rdata = '0;
        endcase
    end

    always_ff @(posedge ck) begin
        if (req) begin
            rdata_q <= reg_rdata;
        end
    end

    assign bus.ack = ack_q;
    assign bus.dat_r = rdata_q;
    assign o_protect_limit = protect_q;

    // An acknowledge always answers a cycle the master opened.
    a_ack_after_cyc: assert property (
        @(posedge ck) disable iff (i_reset)
        bus.ack |-> $past(bus.cyc)
    );

endmodule

`default_nettype wire

//--- source/bus_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module bus_decoder (
    input wire ck,
    input wire i_reset,

    input wire [31:0] i_adr,
    input wire [31:0] i_dat,
    input wire [3:0] i_sel,
    input wire i_we,
    input wire i_cyc,
    input wire i_stb,
    output logic [31:0] o_rdt,
    output logic o_ack,

    wb_if.master ram_bus,
    wb_if.master reg_bus,

    output logic [31:0] o_xbus_adr,
    output logic [31:0] o_xbus_dat,
    output logic [3:0] o_xbus_sel,
    output logic o_xbus_we,
    output logic o_xbus_cyc,
    output logic o_xbus_stb,
    input wire [31:0] i_xbus_rdt,
    input wire i_xbus_ack
);

    logic [1:0] region;
    logic sel_ram;
    logic sel_regs;
    logic sel_ext;

    // The master holds the address until ack, so the region stays valid for the reply.
    assign region = i_adr[31:30];
    assign sel_ram = (region == dbus_pkg::REGION_RAM);
    assign sel_regs = (region == dbus_pkg::REGION_REGS);
    assign sel_ext = region[1];

    // Internal slaves see word addresses.
    assign ram_bus.adr = 32'(i_adr[dbus_pkg::RAM_ADDR_W+1:2]);
    assign ram_bus.dat_w = i_dat;
    assign ram_bus.sel = i_sel;
    assign ram_bus.we = i_we;
    assign ram_bus.cyc = i_cyc;
    assign ram_bus.stb = i_stb & sel_ram;

    assign reg_bus.adr = 32'(i_adr[29:2]);
    assign reg_bus.dat_w = i_dat;
    assign reg_bus.sel = i_sel;
    assign reg_bus.we = i_we;
    assign reg_bus.cyc = i_cyc;
    assign reg_bus.stb = i_stb & sel_regs;

    // The external bus gets the full byte address unchanged.
    assign o_xbus_adr = i_adr;
    assign o_xbus_dat = i_dat;
    assign o_xbus_sel = i_sel;
    assign o_xbus_we = i_we;
    assign o_xbus_cyc = i_cyc & sel_ext;
    assign o_xbus_stb = i_stb & sel_ext;

    always_comb begin
        case (region)
            dbus_pkg::REGION_RAM: begin
                o_rdt = ram_bus.dat_r;
                o_ack = ram_bus.ack;
            end
            dbus_pkg::REGION_REGS: begin
                o_rdt = reg_bus.dat_r;
                o_ack = reg_bus.ack;
            end
            default: begin
                o_rdt = i_xbus_rdt;
                o_ack = i_xbus_ack;
            end
        endcase
    end

    // Only the addressed target may answer.
    a_one_ack: assert property (
        @(posedge ck) disable iff (i_reset)
        $onehot0({ram_bus.ack, reg_bus.ack, i_xbus_ack})
    );

endmodule

`default_nettype wire

//--- source/servant_dbus.sv
`timescale 1ns/10ps
`default_nettype none

module servant_dbus (
    input wire ck,
    input wire i_reset,

    input wire [31:0] i_dbus_adr,
    input wire [31:0] i_dbus_dat,
    input wire [3:0] i_dbus_sel,
    input wire i_dbus_we,
    input wire i_dbus_cyc,
    input wire i_dbus_stb,
    output wire [31:0] o_dbus_rdt,
    output wire o_dbus_ack,

    output wire [31:0] o_xbus_adr,
    output wire [31:0] o_xbus_dat,
    output wire [3:0] o_xbus_sel,
    output wire o_xbus_we,
    output wire o_xbus_cyc,
    output wire o_xbus_stb,
    input wire [31:0] i_xbus_rdt,
    input wire i_xbus_ack
);

    wb_if ram_bus ();
    wb_if reg_bus ();

    logic [dbus_pkg::RAM_ADDR_W:0] protect_limit;
    logic blocked_write;

    bus_decoder decoder (
        .ck         (ck),
        .i_reset    (i_reset),
        .i_adr      (i_dbus_adr),
        .i_dat      (i_dbus_dat),
        .i_sel      (i_dbus_sel),
        .i_we       (i_dbus_we),
        .i_cyc      (i_dbus_cyc),
        .i_stb      (i_dbus_stb),
        .o_rdt      (o_dbus_rdt),
        .o_ack      (o_dbus_ack),
        .ram_bus    (ram_bus.master),
        .reg_bus    (reg_bus.master),
        .o_xbus_adr (o_xbus_adr),
        .o_xbus_dat (o_xbus_dat),
        .o_xbus_sel (o_xbus_sel),
        .o_xbus_we  (o_xbus_we),
        .o_xbus_cyc (o_xbus_cyc),
        .o_xbus_stb (o_xbus_stb),
        .i_xbus_rdt (i_xbus_rdt),
        .i_xbus_ack (i_xbus_ack)
    );

    sp_ram ram (
        .ck              (ck),
        .i_reset         (i_reset),
        .bus             (ram_bus.slave),
        .i_protect_limit (protect_limit),
        .o_blocked_write (blocked_write)
    );

    // Sets the RAM write-protect limit and counts the writes it drops.
    ctrl_regs regs (
        .ck              (ck),
        .i_reset         (i_reset),
        .bus             (reg_bus.slave),
        .i_blocked_write (blocked_write),
        .o_protect_limit (protect_limit)
    );

endmodule

`default_nettype wire

//--- verif/tb_servant_dbus.sv
`timescale 1ns/10ps
`default_nettype none

module tb_servant_dbus;

    localparam int MAX_CYCLES = 20000;
    localparam int TEST_WORDS = 256;
    localparam logic [31:0] XBUS_KEY = 32'ha55a_5aa5;
    localparam logic [31:0] REG_BASE = 32'h4000_0000;

    logic ck = 1'b0;
    logic i_reset;
    logic [31:0] i_dbus_adr;
    logic [31:0] i_dbus_dat;
    logic [3:0] i_dbus_sel;
    logic i_dbus_we;
    logic i_dbus_cyc;
    logic i_dbus_stb;
    wire [31:0] o_dbus_rdt;
    wire o_dbus_ack;
    wire [31:0] o_xbus_adr;
    wire [31:0] o_xbus_dat;
    wire [3:0] o_xbus_sel;
    wire o_xbus_we;
    wire o_xbus_cyc;
    wire o_xbus_stb;
    logic [31:0] xbus_rdt;
    logic xbus_ack;

    // Reference state for the RAM and the register block.
    logic [31:0] shadow_ram [0:dbus_pkg::RAM_WORDS-1];
    logic [dbus_pkg::RAM_ADDR_W:0] shadow_protect;
    logic [31:0] shadow_scratch;
    logic [31:0] shadow_blocked;

    logic [31:0] exp_rdata;
    int checks = 0;
    int errors = 0;
    int cycle_count = 0;

    // Requests seen by the external responder.
    logic [31:0] xq_adr [$];
    logic [31:0] xq_dat [$];
    logic [3:0] xq_sel [$];
    logic xq_we [$];

    servant_dbus dut (
        .ck         (ck),
        .i_reset    (i_reset),
        .i_dbus_adr (i_dbus_adr),
        .i_dbus_dat (i_dbus_dat),
        .i_dbus_sel (i_dbus_sel),
        .i_dbus_we  (i_dbus_we),
        .i_dbus_cyc (i_dbus_cyc),
        .i_dbus_stb (i_dbus_stb),
        .o_dbus_rdt (o_dbus_rdt),
        .o_dbus_ack (o_dbus_ack),
        .o_xbus_adr (o_xbus_adr),
        .o_xbus_dat (o_xbus_dat),
        .o_xbus_sel (o_xbus_sel),
        .o_xbus_we  (o_xbus_we),
        .o_xbus_cyc (o_xbus_cyc),
        .o_xbus_stb (o_xbus_stb),
        .i_xbus_rdt (xbus_rdt),
        .i_xbus_ack (xbus_ack)
    );

    always #4 ck = ~ck;

    always @(posedge ck) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles.", MAX_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED at time %0t: %s, got %h, expected %h",
                     $time, what, got, want);
        end
    endtask

    function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] sel);
        logic [31:0] mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic logic [31:0] expected_read(input logic [31:0] adr);
        logic [31:0] value;
        if (adr[31]) begin
            value = adr ^ XBUS_KEY; // What the external responder returns.
        end else if (adr[31:30] == dbus_pkg::REGION_RAM) begin
            value = shadow_ram[adr[dbus_pkg::RAM_ADDR_W+1:2]];
        end else begin
            case (adr[3:2])
                dbus_pkg::REG_PROTECT: value = 32'(shadow_protect);
                dbus_pkg::REG_SCRATCH: value = shadow_scratch;
                dbus_pkg::REG_BLOCKED: value = shadow_blocked;
                default:               value = dbus_pkg::DBUS_ID;
            endcase
        end
        return value;
    endfunction

    task automatic model_write(input logic [31:0] adr, input logic [31:0] dat,
                               input logic [3:0] sel);
        logic [dbus_pkg::RAM_ADDR_W-1:0] word;
        logic [31:0] merged;
        word = adr[dbus_pkg::RAM_ADDR_W+1:2];
        if (adr[31:30] == dbus_pkg::REGION_RAM) begin
            if ({1'b0, word} < shadow_protect) begin
                shadow_blocked = shadow_blocked + 32'd1; // Dropped by write protection.
            end else begin
                shadow_ram[word] = merge_lanes(shadow_ram[word], dat, sel);
            end
        end else if (adr[31:30] == dbus_pkg::REGION_REGS) begin
            case (adr[3:2])
                dbus_pkg::REG_PROTECT: begin
                    merged = merge_lanes(32'(shadow_protect), dat, sel);
                    shadow_protect = merged[dbus_pkg::RAM_ADDR_W:0];
                end
                dbus_pkg::REG_SCRATCH: shadow_scratch = merge_lanes(shadow_scratch, dat, sel);
                dbus_pkg::REG_BLOCKED: shadow_blocked = 32'd0;
                default: ;
            endcase
        end
    endtask

    task automatic drive_idle();
        i_dbus_adr = 32'd0;
        i_dbus_dat = 32'd0;
        i_dbus_sel = 4'd0;
        i_dbus_we = 1'b0;
        i_dbus_cyc = 1'b0;
        i_dbus_stb = 1'b0;
    endtask

    // Called 1 ns after a rising edge; returns 1 ns after a rising edge.
    task automatic transfer(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, input logic we);
        int cycles;
        if (!we) begin
            exp_rdata = expected_read(adr);
        end
        i_dbus_adr = adr;
        i_dbus_dat = dat;
        i_dbus_sel = sel;
        i_dbus_we = we;
        i_dbus_cyc = 1'b1;
        i_dbus_stb = 1'b1;
        cycles = 0;
        @(negedge ck);
        check_value(32'(o_xbus_cyc), 32'(adr[31]), "external cyc for this region");
        check_value(32'(o_xbus_stb), 32'(adr[31]), "external stb for this region");
        while (!o_dbus_ack) begin
            cycles++;
            @(negedge ck);
        end
        if (!adr[31]) begin
            check_value(32'(cycles), 32'd1, "internal ack latency in cycles");
        end
        @(posedge ck);
        #1;
        i_dbus_cyc = 1'b0; // The same target stays addressed while its ack is watched.
        i_dbus_stb = 1'b0;
        if (we) begin
            model_write(adr, dat, sel);
        end
        @(negedge ck);
        check_value(32'(o_dbus_ack), 32'd0, "ack held longer than one cycle");
        @(posedge ck);
        #1;
        drive_idle();
    endtask

    task automatic write_word(input logic [31:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel);
        transfer(adr, dat, sel, 1'b1);
    endtask

    task automatic read_word(input logic [31:0] adr);
        transfer(adr, 32'd0, 4'd0, 1'b0);
    endtask

    function automatic logic [31:0] ram_addr(input int word);
        return 32'(word) << 2;
    endfunction

    function automatic logic [31:0] reg_addr(input int idx);
        return REG_BASE | (32'(idx) << 2);
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] adr);
        return (adr * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
    endfunction

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("Test %0d (%s) finished with %0d errors", num, name, errors - errs_before);
    endtask

    // Every acknowledged read is compared while the bus is stable.
    always @(negedge ck) begin
        if (!i_reset && i_dbus_cyc && i_dbus_stb && !i_dbus_we && o_dbus_ack) begin
            check_value(o_dbus_rdt, exp_rdata, $sformatf("read data at %h", i_dbus_adr));
        end
    end

    // External slave with a random wait of 0 to 3 cycles.
    initial begin
        logic [31:0] r;
        xbus_ack = 1'b0;
        xbus_rdt = 32'd0;
        forever begin
            @(posedge ck);
            if (!i_reset && o_xbus_cyc && o_xbus_stb) begin
                xq_adr.push_back(o_xbus_adr);
                xq_dat.push_back(o_xbus_dat);
                xq_sel.push_back(o_xbus_sel);
                xq_we.push_back(o_xbus_we);
                r = $urandom;
                repeat (int'(r[1:0])) @(posedge ck);
                #1;
                xbus_rdt = o_xbus_adr ^ XBUS_KEY;
                xbus_ack = 1'b1;
                @(posedge ck);
                #1;
                xbus_ack = 1'b0;
                xbus_rdt = 32'd0;
            end
        end
    end

    initial begin
        int errs_at_start;
        logic [31:0] r;
        logic [31:0] adr;
        logic [31:0] dat;
        void'($urandom(32'h5518_8bf2));
        i_reset = 1'b1;
        drive_idle();
        exp_rdata = 32'd0;
        shadow_protect = '0;
        shadow_scratch = 32'd0;
        shadow_blocked = 32'd0;
        repeat (4) @(posedge ck);
        #1;
        i_reset = 1'b0;

        errs_at_start = errors;
        @(negedge ck);
        check_value(32'(o_dbus_ack), 32'd0, "ack after reset");
        check_value(32'(o_xbus_cyc), 32'd0, "external cyc after reset");
        @(posedge ck);
        #1;
        for (int i = 0; i < 4; i++) begin
            read_word(reg_addr(i));
        end
        report_test(1, "reset values", errs_at_start);

        errs_at_start = errors;
        for (int w = 0; w < TEST_WORDS; w++) begin
            write_word(ram_addr(w), fill_word(ram_addr(w)), 4'hf);
        end
        for (int n = 0; n < 400; n++) begin
            r = $urandom;
            write_word(ram_addr(int'(r[7:0])), $urandom, r[11:8]); // Random byte lanes.
        end
        for (int w = 0; w < TEST_WORDS; w++) begin
            read_word(ram_addr(w));
        end
        report_test(2, "RAM byte-lane writes", errs_at_start);

        errs_at_start = errors;
        for (int n = 0; n < 32; n++) begin
            r = $urandom;
            if (r[0]) begin
                read_word(reg_addr(int'(r[2:1])));
            end else begin
                read_word(ram_addr(int'(r[10:3])));
            end
        end
        report_test(3, "internal ack timing", errs_at_start);

        errs_at_start = errors;
        write_word(reg_addr(int'(dbus_pkg::REG_PROTECT)), 32'habcd_f064, 4'hf);
        read_word(reg_addr(int'(dbus_pkg::REG_PROTECT)));
        for (int n = 0; n < 64; n++) begin
            r = $urandom;
            write_word(ram_addr(int'(r[7:0])), $urandom, 4'hf);
        end
        read_word(reg_addr(int'(dbus_pkg::REG_BLOCKED)));
        for (int w = 0; w < TEST_WORDS; w++) begin
            read_word(ram_addr(w));
        end
        write_word(reg_addr(int'(dbus_pkg::REG_BLOCKED)), 32'h1, 4'h1);
        read_word(reg_addr(int'(dbus_pkg::REG_BLOCKED)));
        write_word(reg_addr(int'(dbus_pkg::REG_PROTECT)), 32'h0000_0200, 4'b0010);
        read_word(reg_addr(int'(dbus_pkg::REG_PROTECT)));
        write_word(ram_addr(150), 32'hdead_beef, 4'hf);
        write_word(ram_addr(700), 32'hcafe_f00d, 4'hf);
        read_word(ram_addr(150));
        read_word(ram_addr(700));
        read_word(reg_addr(int'(dbus_pkg::REG_BLOCKED)));
        write_word(reg_addr(int'(dbus_pkg::REG_PROTECT)), 32'h0, 4'hf);
        write_word(reg_addr(int'(dbus_pkg::REG_SCRATCH)), 32'h1122_3344, 4'hf);
        write_word(reg_addr(int'(dbus_pkg::REG_SCRATCH)), 32'haabb_ccdd, 4'b0101);
        read_word(reg_addr(int'(dbus_pkg::REG_SCRATCH)));
        write_word(reg_addr(int'(dbus_pkg::REG_ID)), 32'hffff_ffff, 4'hf);
        read_word(reg_addr(int'(dbus_pkg::REG_ID)));
        report_test(4, "write protection and registers", errs_at_start);

        errs_at_start = errors;
        for (int n = 0; n < 40; n++) begin
            r = $urandom;
            adr = $urandom;
            adr[31] = 1'b1; // Regions 2 and 3.
            adr[1:0] = 2'b00;
            dat = $urandom;
            transfer(adr, dat, r[3:0], r[4]);
            check_value(32'(xq_adr.size()), 32'd1, "external requests per transfer");
            if (xq_adr.size() == 1) begin
                check_value(xq_adr[0], adr, "external address");
                check_value(xq_dat[0], dat, "external write data");
                check_value(32'(xq_sel[0]), 32'(r[3:0]), "external sel");
                check_value(32'(xq_we[0]), 32'(r[4]), "external we");
            end
            xq_adr.delete();
            xq_dat.delete();
            xq_sel.delete();
            xq_we.delete();
        end
        report_test(5, "external bus forwarding", errs_at_start);

        $display("Checks run: %0d, failures: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- servant_dbus.f
source/dbus_pkg.sv
source/wb_if.sv
source/sp_ram.sv
source/ctrl_regs.sv
source/bus_decoder.sv
source/servant_dbus.sv
verif/tb_servant_dbus.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert \
    --top-module tb_servant_dbus \
    -Mdir "$BUILD" \
    -f servant_dbus.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD/Vtb_servant_dbus" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
